// ==== verilog/spim_pkg.sv ====
/*
  Quad SPI register front end shared definitions
  Flash opcodes, register map, init FSM states and request structs
*/
package spim_pkg;

  // --------------------
  // Flash opcodes
  typedef enum logic [7:0] {
    OP_WRR        = 8'h01,
    OP_WREN       = 8'h06,
    OP_POWER_UP   = 8'hAB,
    OP_QUAD_READ  = 8'hEB
  } flash_op_e;

  // Register index, from address bits 7:4
  typedef enum logic [3:0] {
    REG_CTRL      = 4'd0,
    REG_SPICMD    = 4'd2,
    REG_SPIADR    = 4'd3,
    REG_SPILEN    = 4'd4,
    REG_SPIDUM    = 4'd5,
    REG_SPIWDATA  = 4'd6,
    REG_SPIRDATA  = 4'd7
  } reg_addr_e;

  // Power-up sequencer states
  typedef enum logic [2:0] {
    INIT_PWR_CMD,
    INIT_PWR_WAIT,
    INIT_WREN_CMD,
    INIT_WREN_WAIT,
    INIT_WRR_CMD,
    INIT_WRR_WAIT,
    INIT_DONE
  } init_state_e;

  // --------------------
  // One request towards the SPI engine
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    logic [5:0]  addr_len;
    logic [7:0]  cmd;
    logic [5:0]  cmd_len;
    logic [7:0]  mode;
    logic        mode_enb;
    logic [3:0]  csreg;
    logic [15:0] data_len;
    logic [15:0] dummy_rd_len;
    logic [15:0] dummy_wr_len;
    logic        rd;
    logic        wr;
    logic        qrd;
    logic        qwr;
    logic        swrst;
    logic [31:0] wdata;
  } spi_cmd_t;

  // Registered bus access
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_req_t;

  // --------------------
  // Address bits 31:28 of the two spaces
  localparam logic [3:0] MEM_REGION = 4'h0;
  localparam logic [3:0] REG_REGION = 4'h1;

  // Fixed shape of a direct quad read
  localparam logic [5:0]  QREAD_ADDR_LEN  = 6'd24;
  localparam logic [15:0] QREAD_DATA_LEN  = 16'd32;
  localparam logic [15:0] QREAD_DUMMY_LEN = 16'd32;

endpackage

// ==== verilog/spim_bus_if.sv ====
/*
  Bus front end of the quad SPI register block
  Registers each access, splits memory and register space, returns ack and data
*/
`timescale 1ns/100ps

module spim_bus_if (
  input  logic               mclk,
  input  logic               rst_n,
  input  logic               stb_i,
  input  logic               we_i,
  input  logic [31:0]        adr_i,
  input  logic [31:0]        dat_i,
  input  logic [3:0]         sel_i,
  input  logic               init_done_i,
  input  logic               spi_ack_i,
  input  logic [31:0]        spi_rdata_i,
  input  logic [31:0]        reg_rdata_i,
  input  logic               mem_sel_i,
  output spim_pkg::bus_req_t bus_req_o,
  output logic               mem_rd_o,
  output logic               reg_acc_o,
  output logic [31:0]        dat_o,
  output logic               ack_o
);
  import spim_pkg::*;

  logic        req_q;
  logic        req_l_q;
  logic        we_q;
  logic [3:0]  be_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic        reg_hit;
  logic        reg_done;

  // --------------------
  // Region decode
  // Only reads in memory space go to flash, writes there are dropped
  assign mem_rd_o  = req_q && !we_q && (addr_q[31:28] == MEM_REGION);
  assign reg_hit   = req_q && (addr_q[31:28] == REG_REGION);
  // Write strobe for the register bank, first registered cycle only
  assign reg_acc_o = reg_hit && !req_l_q;
  // Non-flash accesses finish on the second registered cycle
  assign reg_done  = req_q && req_l_q && !ack_o;

  assign bus_req_o = '{valid: req_q, we: we_q, be: be_q, addr: addr_q, wdata: wdata_q};

  // --------------------
  // Request and acknowledge
  always_ff @(posedge mclk)
  begin
    if (!rst_n)
    begin
      req_q   <= 1'b0;
      req_l_q <= 1'b0;
      ack_o   <= 1'b0;
    end
    else
    begin
      // Bus held off until the flash is set up
      // Drop the request once the flash read completes
      req_q   <= stb_i && init_done_i && !ack_o && !(mem_sel_i && spi_ack_i);
      req_l_q <= req_q;
      // Flash read acks on the engine ack, everything else after two cycles
      ack_o   <= mem_sel_i ? spi_ack_i : reg_done;
    end
  end

  // Access fields, held stable by the master until ack
  always_ff @(posedge mclk)
  begin
    if (stb_i)
    begin
      we_q    <= we_i;
      be_q    <= sel_i;
      addr_q  <= adr_i;
      wdata_q <= dat_i;
    end
  end

  // Read data lines up with ack_o
  always_ff @(posedge mclk)
  begin
    if (mem_sel_i && spi_ack_i)
      dat_o <= spi_rdata_i;
    else if (reg_done && reg_hit)
      dat_o <= reg_rdata_i;
  end

endmodule

// ==== verilog/spim_reg_file.sv ====
/*
  Indirect flash access register bank
  Holds the programmed SPI command, launches it and captures its read data
*/
`timescale 1ns/100ps

module spim_reg_file (
  input  logic               mclk,
  input  logic               rst_n,
  input  spim_pkg::bus_req_t bus_req_i,
  input  logic               reg_acc_i,
  input  logic               spi_ack_i,
  input  logic [31:0]        spi_rdata_i,
  input  logic               mem_sel_i,
  output spim_pkg::spi_cmd_t reg_cmd_o,
  output logic [31:0]        reg_rdata_o
);
  import spim_pkg::*;

  spi_cmd_t    cmd_q;
  logic [31:0] rdata_q;
  reg_addr_e   reg_idx;
  logic        wr_en;
  logic        xfer_done;

  assign reg_idx   = reg_addr_e'(bus_req_i.addr[7:4]);
  assign wr_en     = reg_acc_i && bus_req_i.we;
  // Engine ack belongs to this bank only while no direct read holds the engine
  assign xfer_done = cmd_q.req && spi_ack_i && !mem_sel_i;
  assign reg_cmd_o = cmd_q;

  // --------------------
  // Register writes
  always_ff @(posedge mclk)
  begin
    if (!rst_n)
    begin
      cmd_q   <= '0;
      rdata_q <= '0;
    end
    else
    begin
      if (xfer_done)
      begin
        cmd_q.req <= 1'b0;
        // Keep read data of rd and qrd transfers
        if (cmd_q.rd || cmd_q.qrd)
          rdata_q <= spi_rdata_i;
      end
      if (wr_en)
      begin
        case (reg_idx)
          REG_CTRL:
          begin
            // Byte 0 holds the transfer type and fires the request
            if (bus_req_i.be[0])
            begin
              cmd_q.rd    <= bus_req_i.wdata[0];
              cmd_q.wr    <= bus_req_i.wdata[1];
              cmd_q.qrd   <= bus_req_i.wdata[2];
              cmd_q.qwr   <= bus_req_i.wdata[3];
              cmd_q.swrst <= bus_req_i.wdata[4];
              cmd_q.req   <= 1'b1;
            end
            if (bus_req_i.be[1])
              cmd_q.csreg <= bus_req_i.wdata[11:8];
          end
          REG_SPICMD:
          begin
            if (bus_req_i.be[0])
              cmd_q.cmd <= bus_req_i.wdata[7:0];
            if (bus_req_i.be[1])
              cmd_q.mode <= bus_req_i.wdata[15:8];
          end
          REG_SPIADR:
          begin
            for (int b = 0; b < 4; b++)
            begin
              if (bus_req_i.be[b])
                cmd_q.addr[b*8 +: 8] <= bus_req_i.wdata[b*8 +: 8];
            end
          end
          REG_SPILEN:
          begin
            if (bus_req_i.be[0])
            begin
              cmd_q.mode_enb <= bus_req_i.wdata[6];
              cmd_q.cmd_len  <= bus_req_i.wdata[5:0];
            end
            if (bus_req_i.be[1])
              cmd_q.addr_len <= bus_req_i.wdata[13:8];
            if (bus_req_i.be[2])
              cmd_q.data_len[7:0] <= bus_req_i.wdata[23:16];
            if (bus_req_i.be[3])
              cmd_q.data_len[15:8] <= bus_req_i.wdata[31:24];
          end
          REG_SPIDUM:
          begin
            // Dummy write length is stored only, engine takes it as is
            if (bus_req_i.be[0])
              cmd_q.dummy_rd_len[7:0] <= bus_req_i.wdata[7:0];
            if (bus_req_i.be[1])
              cmd_q.dummy_rd_len[15:8] <= bus_req_i.wdata[15:8];
            if (bus_req_i.be[2])
              cmd_q.dummy_wr_len[7:0] <= bus_req_i.wdata[23:16];
            if (bus_req_i.be[3])
              cmd_q.dummy_wr_len[15:8] <= bus_req_i.wdata[31:24];
          end
          REG_SPIWDATA:
          begin
            for (int b = 0; b < 4; b++)
            begin
              if (bus_req_i.be[b])
                cmd_q.wdata[b*8 +: 8] <= bus_req_i.wdata[b*8 +: 8];
            end
          end
          // Read data register is read only
          default:
            ;
        endcase
      end
    end
  end

  // --------------------
  // Read mux
  always_comb
  begin
    case (reg_idx)
      REG_CTRL:
        reg_rdata_o = {20'h0, cmd_q.csreg, 3'b000, cmd_q.swrst,
                       cmd_q.qwr, cmd_q.qrd, cmd_q.wr, cmd_q.rd};
      REG_SPICMD:   reg_rdata_o = {16'h0, cmd_q.mode, cmd_q.cmd};
      REG_SPIADR:   reg_rdata_o = cmd_q.addr;
      REG_SPILEN:
        reg_rdata_o = {cmd_q.data_len, 2'b00, cmd_q.addr_len,
                       1'b0, cmd_q.mode_enb, cmd_q.cmd_len};
      REG_SPIDUM:   reg_rdata_o = {cmd_q.dummy_wr_len, cmd_q.dummy_rd_len};
      REG_SPIWDATA: reg_rdata_o = cmd_q.wdata;
      REG_SPIRDATA: reg_rdata_o = rdata_q;
      default:      reg_rdata_o = '0;
    endcase
  end

endmodule

// ==== verilog/spim_init_seq.sv ====
/*
  Flash power-up sequencer
  Sends power-up, write enable and configuration write once after reset
*/
`timescale 1ns/100ps

module spim_init_seq #(
  parameter logic [7:0] INIT_CR1 = 8'h02
) (
  input  logic               mclk,
  input  logic               rst_n,
  input  logic               spi_ack_i,
  output spim_pkg::spi_cmd_t init_cmd_o,
  output logic               init_done_o
);
  import spim_pkg::*;

  init_state_e state_q;
  init_state_e state_d;

  // --------------------
  // Next state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      // First cycle out of reset, request raised from the next one
      INIT_PWR_CMD:   state_d = INIT_PWR_WAIT;
      INIT_PWR_WAIT:  state_d = spi_ack_i ? INIT_WREN_CMD : INIT_PWR_WAIT;
      INIT_WREN_CMD:  state_d = spi_ack_i ? INIT_WRR_CMD : INIT_WREN_WAIT;
      INIT_WREN_WAIT: state_d = spi_ack_i ? INIT_WRR_CMD : INIT_WREN_WAIT;
      INIT_WRR_CMD:   state_d = spi_ack_i ? INIT_DONE : INIT_WRR_WAIT;
      INIT_WRR_WAIT:  state_d = spi_ack_i ? INIT_DONE : INIT_WRR_WAIT;
      default:        state_d = INIT_DONE;
    endcase
  end

  always_ff @(posedge mclk)
  begin
    if (!rst_n)
      state_q <= INIT_PWR_CMD;
    else
      state_q <= state_d;
  end

  // --------------------
  // Command per state
  // All three are plain writes on chip select 1 with an 8 bit opcode
  always_comb
  begin
    init_cmd_o         = '0;
    init_cmd_o.req     = (state_q != INIT_PWR_CMD) && (state_q != INIT_DONE);
    init_cmd_o.wr      = 1'b1;
    init_cmd_o.csreg   = 4'h1;
    init_cmd_o.cmd_len = 6'd8;
    case (state_q)
      INIT_PWR_CMD, INIT_PWR_WAIT:   init_cmd_o.cmd = OP_POWER_UP;
      INIT_WREN_CMD, INIT_WREN_WAIT: init_cmd_o.cmd = OP_WREN;
      default:
      begin
        // Status byte then config byte, config carries quad enable
        init_cmd_o.cmd      = OP_WRR;
        init_cmd_o.data_len = 16'd16;
        init_cmd_o.wdata    = {8'h00, INIT_CR1, 16'h0000};
      end
    endcase
  end

  assign init_done_o = (state_q == INIT_DONE);

endmodule

// ==== verilog/spim_cmd_arb.sv ====
/*
  SPI engine command select
  Builds the direct quad read and picks init, memory or register command
*/
`timescale 1ns/100ps

module spim_cmd_arb (
  input  logic               init_done_i,
  input  logic               mem_rd_i,
  input  logic [31:0]        bus_addr_i,
  input  spim_pkg::spi_cmd_t init_cmd_i,
  input  spim_pkg::spi_cmd_t reg_cmd_i,
  output spim_pkg::spi_cmd_t spi_cmd_o,
  output logic               mem_sel_o
);
  import spim_pkg::*;

  spi_cmd_t mem_cmd;

  // --------------------
  // Direct quad read, fixed shape
  always_comb
  begin
    mem_cmd              = '0;
    mem_cmd.req          = 1'b1;
    // 24 bit flash address sent from the top byte
    mem_cmd.addr         = {bus_addr_i[23:0], 8'h00};
    mem_cmd.addr_len     = QREAD_ADDR_LEN;
    mem_cmd.cmd          = OP_QUAD_READ;
    mem_cmd.cmd_len      = 6'd8;
    mem_cmd.mode         = 8'h00;
    mem_cmd.mode_enb     = 1'b1;
    mem_cmd.csreg        = 4'hF;
    mem_cmd.data_len     = QREAD_DATA_LEN;
    mem_cmd.dummy_rd_len = QREAD_DUMMY_LEN;
    mem_cmd.qrd          = 1'b1;
  end

  // Init owns the engine until done, then memory reads beat register commands
  assign mem_sel_o = init_done_i && mem_rd_i;
  assign spi_cmd_o = !init_done_i ? init_cmd_i :
                     mem_sel_o    ? mem_cmd    : reg_cmd_i;

endmodule

// ==== verilog/spim_regs_top.sv ====
/*
  Quad SPI flash register front end, top level
*/
`timescale 1ns/100ps

module spim_regs_top #(
  parameter logic [7:0] INIT_CR1 = 8'h02
) (
  input  logic               mclk,
  input  logic               rst_n,
  input  logic               stb_i,
  input  logic               we_i,
  input  logic [31:0]        adr_i,
  input  logic [31:0]        dat_i,
  input  logic [3:0]         sel_i,
  output logic [31:0]        dat_o,
  output logic               ack_o,
  output spim_pkg::spi_cmd_t spi_cmd_o,
  input  logic [31:0]        spi_rdata_i,
  input  logic               spi_ack_i
);
  import spim_pkg::*;

  bus_req_t    bus_req;
  logic        mem_rd;
  logic        reg_acc;
  spi_cmd_t    reg_cmd;
  logic [31:0] reg_rdata;
  spi_cmd_t    init_cmd;
  logic        init_done;
  logic        mem_sel;

  // --------------------
  // Bus side
  spim_bus_if u_bus_if (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .sel_i       (sel_i),
    .init_done_i (init_done),
    .spi_ack_i   (spi_ack_i),
    .spi_rdata_i (spi_rdata_i),
    .reg_rdata_i (reg_rdata),
    .mem_sel_i   (mem_sel),
    .bus_req_o   (bus_req),
    .mem_rd_o    (mem_rd),
    .reg_acc_o   (reg_acc),
    .dat_o       (dat_o),
    .ack_o       (ack_o)
  );

  // Indirect access registers
  spim_reg_file u_reg_file (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .bus_req_i   (bus_req),
    .reg_acc_i   (reg_acc),
    .spi_ack_i   (spi_ack_i),
    .spi_rdata_i (spi_rdata_i),
    .mem_sel_i   (mem_sel),
    .reg_cmd_o   (reg_cmd),
    .reg_rdata_o (reg_rdata)
  );

  // Flash setup after reset
  spim_init_seq #(
    .INIT_CR1 (INIT_CR1)
  ) u_init_seq (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .spi_ack_i   (spi_ack_i),
    .init_cmd_o  (init_cmd),
    .init_done_o (init_done)
  );

  // Engine command select
  spim_cmd_arb u_cmd_arb (
    .init_done_i (init_done),
    .mem_rd_i    (mem_rd),
    .bus_addr_i  (bus_req.addr),
    .init_cmd_i  (init_cmd),
    .reg_cmd_i   (reg_cmd),
    .spi_cmd_o   (spi_cmd_o),
    .mem_sel_o   (mem_sel)
  );

endmodule

// ==== test/spim_engine_model.sv ====
/*
  Behavioral SPI engine for the register front end testbench
  Accepts one command at a time, acks after a random delay
*/
`timescale 1ns/100ps

module spim_engine_model (
  input  logic               mclk,
  input  logic               rst_n,
  input  spim_pkg::spi_cmd_t cmd_i,
  output logic [31:0]        rdata_o,
  output logic               ack_o,
  output spim_pkg::spi_cmd_t last_cmd_o,
  output logic [31:0]        cmd_cnt_o,
  output logic               idle_o
);
  import spim_pkg::*;

  // Known values from time zero, before the first reset edge
  logic        busy_q  = 1'b0;
  logic        ack_q   = 1'b0;
  logic [3:0]  wait_q  = 4'd0;
  logic [31:0] rdata_q = 32'h0;
  logic [31:0] cnt_q   = 32'h0;
  spi_cmd_t    last_q  = '0;

  // --------------------
  // Accept, wait 1 to 8 cycles, then ack with address derived data
  always @(posedge mclk)
  begin
    if (!rst_n)
    begin
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
      cnt_q  <= 32'h0;
    end
    else
    begin
      ack_q <= 1'b0;
      if (busy_q)
      begin
        if (wait_q == 4'd0)
        begin
          ack_q   <= 1'b1;
          rdata_q <= last_q.addr ^ 32'hA5A5A5A5;
          busy_q  <= 1'b0;
        end
        else
          wait_q <= wait_q - 4'd1;
      end
      // Request is still high during the ack cycle, skip it there
      else if (cmd_i.req && !ack_q)
      begin
        busy_q <= 1'b1;
        wait_q <= 4'($urandom % 8);
        last_q <= cmd_i;
        cnt_q  <= cnt_q + 32'd1;
      end
    end
  end

  assign rdata_o    = rdata_q;
  assign ack_o      = ack_q;
  assign last_cmd_o = last_q;
  assign cmd_cnt_o  = cnt_q;
  assign idle_o     = !busy_q && !ack_q;

endmodule

// ==== test/tb_spim_regs.sv ====
/*
  Testbench for the quad SPI register front end
  Checks the power-up commands, then runs bus accesses from the tests file
*/
`timescale 1ns/100ps

module tb_spim_regs;
  import spim_pkg::*;

  localparam int MAX_WORDS = 640;

  logic        mclk = 1'b0;
  logic        rst_n;
  logic        stb;
  logic        we;
  logic [31:0] adr;
  logic [31:0] dat;
  logic [3:0]  sel;
  logic [31:0] dat_out;
  logic        ack;
  spi_cmd_t    spi_cmd;
  logic [31:0] spi_rdata;
  logic        spi_ack;
  spi_cmd_t    last_cmd;
  logic [31:0] cmd_cnt;
  logic        eng_idle;

  // Five words per access: op, address, write data, byte enables, expected
  logic [31:0] vec [0:MAX_WORDS-1];
  // Expected register contents, whole bytes as written
  logic [31:0] regs [0:7];
  int          n_tests;
  logic        tests_loaded = 1'b0;

  always #50 mclk = ~mclk;

  spim_regs_top dut (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .stb_i       (stb),
    .we_i        (we),
    .adr_i       (adr),
    .dat_i       (dat),
    .sel_i       (sel),
    .dat_o       (dat_out),
    .ack_o       (ack),
    .spi_cmd_o   (spi_cmd),
    .spi_rdata_i (spi_rdata),
    .spi_ack_i   (spi_ack)
  );

  spim_engine_model u_engine (
    .mclk       (mclk),
    .rst_n      (rst_n),
    .cmd_i      (spi_cmd),
    .rdata_o    (spi_rdata),
    .ack_o      (spi_ack),
    .last_cmd_o (last_cmd),
    .cmd_cnt_o  (cmd_cnt),
    .idle_o     (eng_idle)
  );

  // --------------------
  // Checks
  task automatic fail_run;
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_data(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_cmd(input string what, input spi_cmd_t got, input spi_cmd_t exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
      fail_run();
    end
  endtask

  // --------------------
  // Expected commands
  function automatic spi_cmd_t init_expect(input int idx);
    spi_cmd_t c;
    c         = '0;
    c.req     = 1'b1;
    c.wr      = 1'b1;
    c.csreg   = 4'h1;
    c.cmd_len = 6'd8;
    case (idx)
      0:       c.cmd = OP_POWER_UP;
      1:       c.cmd = OP_WREN;
      default:
      begin
        // Configuration byte with quad enable lands in byte 2
        c.cmd      = OP_WRR;
        c.data_len = 16'd16;
        c.wdata    = 32'h0002_0000;
      end
    endcase
    return c;
  endfunction

  function automatic spi_cmd_t qread_expect(input logic [31:0] addr);
    spi_cmd_t c;
    c              = '0;
    c.req          = 1'b1;
    c.addr         = {addr[23:0], 8'h00};
    c.addr_len     = QREAD_ADDR_LEN;
    c.cmd          = OP_QUAD_READ;
    c.cmd_len      = 6'd8;
    c.mode_enb     = 1'b1;
    c.csreg        = 4'hF;
    c.data_len     = QREAD_DATA_LEN;
    c.dummy_rd_len = QREAD_DUMMY_LEN;
    c.qrd          = 1'b1;
    return c;
  endfunction

  // Indirect command from the register layout
  function automatic spi_cmd_t regs_expect();
    spi_cmd_t c;
    c              = '0;
    c.req          = 1'b1;
    c.rd           = regs[0][0];
    c.wr           = regs[0][1];
    c.qrd          = regs[0][2];
    c.qwr          = regs[0][3];
    c.swrst        = regs[0][4];
    c.csreg        = regs[0][11:8];
    c.cmd          = regs[2][7:0];
    c.mode         = regs[2][15:8];
    c.addr         = regs[3];
    c.cmd_len      = regs[4][5:0];
    c.mode_enb     = regs[4][6];
    c.addr_len     = regs[4][13:8];
    c.data_len     = regs[4][31:16];
    c.dummy_rd_len = regs[5][15:0];
    c.dummy_wr_len = regs[5][31:16];
    c.wdata        = regs[6];
    return c;
  endfunction

  // --------------------
  // Bus driving, 10 ns after the rising edge
  task automatic step;
    @(posedge mclk);
    #10;
  endtask

  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output logic [31:0] rdata);
    stb = 1'b1;
    we  = wr;
    adr = addr;
    dat = data;
    sel = be;
    do
      step();
    while (!ack);
    rdata = dat_out;
    stb   = 1'b0;
    we    = 1'b0;
  endtask

  // Watchdog, 40 cycles per access plus setup margin
  initial
  begin
    wait (tests_loaded);
    repeat (n_tests * 40 + 200) @(posedge mclk);
    $display("No acknowledge arrived within %0d cycles", n_tests * 40 + 200);
    fail_run();
  end

  // --------------------
  // Main sequence
  initial
  begin
    int unsigned seed;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    logic [31:0] expect_val;
    logic [31:0] rdata;
    logic [31:0] exp_cnt;
    logic        is_reg;
    seed  = $urandom(32'hb07a);
    rst_n = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = 32'h0;
    dat   = 32'h0;
    sel   = 4'h0;
    for (int r = 0; r < 8; r++)
      regs[r] = 32'h0;
    $readmemh("test/spim_regs_tests.txt", vec);
    n_tests = 0;
    while ((n_tests * 5 < MAX_WORDS) && (vec[n_tests * 5] != 32'hF))
      n_tests++;
    tests_loaded = 1'b1;
    repeat (4) @(posedge mclk);
    #10;
    rst_n = 1'b1;

    // Power-up commands come first, one per engine ack
    for (int i = 0; i < 3; i++)
    begin
      while (cmd_cnt == i)
        step();
      check_cmd($sformatf("init command %0d", i), last_cmd, init_expect(i));
    end
    exp_cnt = 32'd3;

    for (int t = 0; t < n_tests; t++)
    begin
      op         = vec[t*5];
      addr       = vec[t*5+1];
      data       = vec[t*5+2];
      be         = vec[t*5+3][3:0];
      expect_val = vec[t*5+4];
      is_reg     = (addr[31:28] == REG_REGION);
      bus_access(op == 32'h1, addr, data, be, rdata);
      if (op == 32'h0)
        check_data($sformatf("read of %h", addr), rdata, expect_val);
      // Register bank writes, the read data register is read only
      if (op == 32'h1 && is_reg && addr[7:4] != REG_SPIRDATA)
      begin
        for (int b = 0; b < 4; b++)
        begin
          if (be[b])
            regs[addr[7:4]][b*8 +: 8] = data[b*8 +: 8];
        end
      end
      if (op == 32'h0 && addr[31:28] == MEM_REGION)
      begin
        // Direct read went to flash as a quad read
        exp_cnt = exp_cnt + 32'd1;
        check_data("command count", cmd_cnt, exp_cnt);
        check_cmd($sformatf("quad read of %h", addr), last_cmd, qread_expect(addr));
      end
      else if (op == 32'h1 && is_reg && addr[7:4] == REG_CTRL && be[0])
      begin
        // Indirect transfer, wait for the engine to finish it
        exp_cnt = exp_cnt + 32'd1;
        while (cmd_cnt != exp_cnt || !eng_idle)
          step();
        check_cmd("indirect command", last_cmd, regs_expect());
      end
      else
        check_data($sformatf("command count after %h", addr), cmd_cnt, exp_cnt);
      step();
    end

    $display("** PASS **");
    $finish;
  end

endmodule

// ==== test/spim_regs_tests.txt ====
// Columns: op (0 read, 1 write, F end), address, write data, byte enables, expected read
// Register reads expect whole words, memory reads expect {A[23:0],8'h00} ^ A5A5A5A5
0 00123456 00000000 F B791F3A5
0 0ABCDEF0 00000000 F 197B55A5
1 10000030 11223344 F 00000000
0 10000030 00000000 F 11223344
1 10000030 AABBCCDD 5 00000000
0 10000030 00000000 F 11BB33DD
1 10000060 CAFEF00D A 00000000
0 10000060 00000000 F CA00F000
1 10000040 00201808 F 00000000
1 10000040 FFFFFF48 1 00000000
0 10000040 00000000 F 00201848
1 10000050 00080020 3 00000000
0 10000050 00000000 F 00000020
1 10000020 0000A5EB 1 00000000
0 10000020 00000000 F 000000EB
1 10000000 00000F01 3 00000000
0 10000000 00000000 F 00000F01
0 10000070 00000000 F B41E9678
1 00000040 DEADBEEF F 00000000
0 10000030 00000000 F 11BB33DD
0 10000040 00000000 F 00201848
0 10000070 00000000 F B41E9678
0 10000060 00000000 F CA00F000
0 10000000 00000000 F 00000F01
F 00000000 00000000 0 00000000

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_spim_regs
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
verilog/spim_pkg.sv
verilog/spim_bus_if.sv
verilog/spim_reg_file.sv
verilog/spim_init_seq.sv
verilog/spim_cmd_arb.sv
verilog/spim_regs_top.sv
test/spim_engine_model.sv
test/tb_spim_regs.sv
